/* source/rv_pkg.sv */
package rv_pkg;

    typedef logic [63:0] xlen_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [31:0] inst_t;
    typedef logic [7:0]  mem_addr_t;
    typedef logic [6:0]  opcode_t;

    localparam int DMEM_WORDS = 32;

    // major opcodes of the supported instruction groups.
    localparam opcode_t OPC_OP     = 7'b0110011;
    localparam opcode_t OPC_OP_IMM = 7'b0010011;
    localparam opcode_t OPC_LUI    = 7'b0110111;
    localparam opcode_t OPC_LOAD   = 7'b0000011;
    localparam opcode_t OPC_STORE  = 7'b0100011;
    localparam opcode_t OPC_SYSTEM = 7'b1110011;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_PASS_B
    } alu_op_e;

    // size and sign of a memory access. MEM_NONE marks a plain ALU instruction.
    typedef enum logic [2:0] {
        MEM_NONE,
        MEM_B,
        MEM_H,
        MEM_W,
        MEM_D,
        MEM_BU,
        MEM_HU,
        MEM_WU
    } mem_kind_e;

endpackage

/* source/ex_mem_if.sv */
`timescale 1ns/1ps

// the receiver samples this stage bundle on an advancing edge.
interface ex_mem_if;

    import rv_pkg::*;

    logic      valid;
    reg_idx_t  rd_index;
    logic      rd_en;
    logic      mem_read;
    logic      mem_write;
    mem_kind_e mem_kind;
    logic      trap;
    xlen_t     result;
    xlen_t     store_data;

    modport src (
        output valid,
        output rd_index,
        output rd_en,
        output mem_read,
        output mem_write,
        output mem_kind,
        output trap,
        output result,
        output store_data
    );

    modport dst (
        input valid,
        input rd_index,
        input rd_en,
        input mem_read,
        input mem_write,
        input mem_kind,
        input trap,
        input result,
        input store_data
    );

endinterface

/* source/reg_file.sv */
`timescale 1ns/1ps

module reg_file (
    input  logic             clk,
    input  logic             rst,
    input  rv_pkg::reg_idx_t ra_i,
    input  rv_pkg::reg_idx_t rb_i,
    input  logic             we_i,
    input  rv_pkg::reg_idx_t wa_i,
    input  rv_pkg::xlen_t    wd_i,
    output rv_pkg::xlen_t    rda_o,
    output rv_pkg::xlen_t    rdb_o
);

    import rv_pkg::*;

    xlen_t regs [32];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && (wa_i != 5'd0)) begin
            regs[wa_i] <= wd_i;
        end
    end

    // a write in the same cycle is passed straight through to the reader.
    assign rda_o = (ra_i == 5'd0) ? '0 :
                   (we_i && (wa_i == ra_i)) ? wd_i : regs[ra_i];

    assign rdb_o = (rb_i == 5'd0) ? '0 :
                   (we_i && (wa_i == rb_i)) ? wd_i : regs[rb_i];

endmodule

/* source/inst_decode.sv */
`timescale 1ns/1ps

module inst_decode (
    input  logic              clk,
    input  logic              rst,
    input  logic              advance_i,
    input  logic              inst_valid_i,
    input  rv_pkg::inst_t     inst_i,
    input  rv_pkg::xlen_t     rs1_data_i,
    input  rv_pkg::xlen_t     rs2_data_i,
    output rv_pkg::reg_idx_t  rs1_index_o,
    output rv_pkg::reg_idx_t  rs2_index_o,
    output logic              valid_o,
    output rv_pkg::alu_op_e   alu_op_o,
    output rv_pkg::xlen_t     op_a_o,
    output rv_pkg::xlen_t     op_b_o,
    output rv_pkg::xlen_t     store_data_o,
    output rv_pkg::reg_idx_t  rd_index_o,
    output logic              rd_en_o,
    output logic              mem_read_o,
    output logic              mem_write_o,
    output rv_pkg::mem_kind_e mem_kind_o,
    output logic              trap_o
);

    import rv_pkg::*;

    logic [2:0] funct3;
    logic [6:0] funct7;
    xlen_t      imm_i;
    xlen_t      imm_s;
    xlen_t      imm_u;

    logic       dec_ok;
    logic       dec_valid;
    alu_op_e    dec_alu_op;
    xlen_t      dec_op_b;
    logic       dec_rd_en;
    logic       dec_mem_read;
    logic       dec_mem_write;
    mem_kind_e  dec_mem_kind;
    logic       dec_trap;

    assign funct3      = inst_i[14:12];
    assign funct7      = inst_i[31:25];
    assign rs1_index_o = inst_i[19:15];
    assign rs2_index_o = inst_i[24:20];

    assign imm_i = {{52{inst_i[31]}}, inst_i[31:20]};
    assign imm_s = {{52{inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
    assign imm_u = {{32{inst_i[31]}}, inst_i[31:12], 12'b0};

    //////////////////////////////
    // instruction decode.
    //////////////////////////////
    always_comb begin
        dec_ok        = 1'b0;
        dec_alu_op    = ALU_ADD;
        dec_op_b      = imm_i;
        dec_rd_en     = 1'b0;
        dec_mem_read  = 1'b0;
        dec_mem_write = 1'b0;
        dec_mem_kind  = MEM_NONE;
        dec_trap      = 1'b0;
        case (inst_i[6:0])
            OPC_OP: begin
                dec_op_b  = rs2_data_i;
                dec_rd_en = 1'b1;
                dec_ok    = (funct7 == 7'b0000000);
                case (funct3)
                    3'b000: begin
                        dec_alu_op = (funct7 == 7'b0100000) ? ALU_SUB : ALU_ADD;
                        dec_ok     = (funct7 == 7'b0000000) || (funct7 == 7'b0100000);
                    end
                    3'b001: dec_alu_op = ALU_SLL;
                    3'b100: dec_alu_op = ALU_XOR;
                    3'b101: dec_alu_op = ALU_SRL;
                    3'b110: dec_alu_op = ALU_OR;
                    3'b111: dec_alu_op = ALU_AND;
                    default: dec_ok = 1'b0;
                endcase
            end
            OPC_OP_IMM: begin
                dec_rd_en = 1'b1;
                dec_ok    = 1'b1;
                case (funct3)
                    3'b000: dec_alu_op = ALU_ADD;
                    3'b100: dec_alu_op = ALU_XOR;
                    3'b110: dec_alu_op = ALU_OR;
                    3'b111: dec_alu_op = ALU_AND;
                    default: dec_ok = 1'b0;
                endcase
            end
            OPC_LUI: begin
                dec_alu_op = ALU_PASS_B;
                dec_op_b   = imm_u;
                dec_rd_en  = 1'b1;
                dec_ok     = 1'b1;
            end
            OPC_LOAD: begin
                dec_rd_en    = 1'b1;
                dec_mem_read = 1'b1;
                dec_ok       = 1'b1;
                case (funct3)
                    3'b000: dec_mem_kind = MEM_B;
                    3'b001: dec_mem_kind = MEM_H;
                    3'b010: dec_mem_kind = MEM_W;
                    3'b011: dec_mem_kind = MEM_D;
                    3'b100: dec_mem_kind = MEM_BU;
                    3'b101: dec_mem_kind = MEM_HU;
                    3'b110: dec_mem_kind = MEM_WU;
                    default: dec_ok = 1'b0;
                endcase
            end
            OPC_STORE: begin
                dec_op_b      = imm_s;
                dec_mem_write = 1'b1;
                dec_ok        = !funct3[2];
                case (funct3[1:0])
                    2'b00: dec_mem_kind = MEM_B;
                    2'b01: dec_mem_kind = MEM_H;
                    2'b10: dec_mem_kind = MEM_W;
                    default: dec_mem_kind = MEM_D;
                endcase
            end
            OPC_SYSTEM: begin
                // ecall and ebreak differ only in bit 20.
                dec_trap = 1'b1;
                dec_ok   = (inst_i[31:21] == 11'b0) && (inst_i[19:7] == 13'b0);
            end
            default: dec_ok = 1'b0;
        endcase

        dec_valid = dec_ok && inst_valid_i;
        if (!dec_valid) begin
            dec_alu_op    = ALU_ADD;
            dec_rd_en     = 1'b0;
            dec_mem_read  = 1'b0;
            dec_mem_write = 1'b0;
            dec_mem_kind  = MEM_NONE;
            dec_trap      = 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_o      <= 1'b0;
            alu_op_o     <= ALU_ADD;
            op_a_o       <= '0;
            op_b_o       <= '0;
            store_data_o <= '0;
            rd_index_o   <= '0;
            rd_en_o      <= 1'b0;
            mem_read_o   <= 1'b0;
            mem_write_o  <= 1'b0;
            mem_kind_o   <= MEM_NONE;
            trap_o       <= 1'b0;
        end else if (advance_i) begin
            valid_o      <= dec_valid;
            alu_op_o     <= dec_alu_op;
            op_a_o       <= rs1_data_i;
            op_b_o       <= dec_op_b;
            store_data_o <= rs2_data_i;
            rd_index_o   <= inst_i[11:7];
            rd_en_o      <= dec_rd_en;
            mem_read_o   <= dec_mem_read;
            mem_write_o  <= dec_mem_write;
            mem_kind_o   <= dec_mem_kind;
            trap_o       <= dec_trap;
        end
    end

endmodule

/* source/alu_execute.sv */
`timescale 1ns/1ps

module alu_execute (
    input  logic              valid_i,
    input  rv_pkg::alu_op_e   alu_op_i,
    input  rv_pkg::xlen_t     op_a_i,
    input  rv_pkg::xlen_t     op_b_i,
    input  rv_pkg::xlen_t     store_data_i,
    input  rv_pkg::reg_idx_t  rd_index_i,
    input  logic              rd_en_i,
    input  logic              mem_read_i,
    input  logic              mem_write_i,
    input  rv_pkg::mem_kind_e mem_kind_i,
    input  logic              trap_i,
    ex_mem_if.src             ex_o
);

    import rv_pkg::*;

    logic [5:0] shamt;
    xlen_t      alu_result;

    // rv64 shifts take six bits of shift amount.
    assign shamt = op_b_i[5:0];

    // loads and stores arrive as ALU_ADD, so the result is the address.
    always_comb begin
        case (alu_op_i)
            ALU_ADD:    alu_result = op_a_i + op_b_i;
            ALU_SUB:    alu_result = op_a_i - op_b_i;
            ALU_AND:    alu_result = op_a_i & op_b_i;
            ALU_OR:     alu_result = op_a_i | op_b_i;
            ALU_XOR:    alu_result = op_a_i ^ op_b_i;
            ALU_SLL:    alu_result = op_a_i << shamt;
            ALU_SRL:    alu_result = op_a_i >> shamt;
            ALU_PASS_B: alu_result = op_b_i;
            default:    alu_result = '0;
        endcase
    end

    assign ex_o.valid      = valid_i;
    assign ex_o.rd_index   = rd_index_i;
    assign ex_o.rd_en      = rd_en_i;
    assign ex_o.mem_read   = mem_read_i;
    assign ex_o.mem_write  = mem_write_i;
    assign ex_o.mem_kind   = mem_kind_i;
    assign ex_o.trap       = trap_i;
    assign ex_o.result     = alu_result;
    assign ex_o.store_data = store_data_i;

endmodule

/* source/ex2mem.sv */
`timescale 1ns/1ps

module ex2mem (
    input  logic  clk,
    input  logic  rst,
    input  logic  advance_i,
    input  logic  flush_i,
    ex_mem_if.dst ex_i,
    ex_mem_if.src mem_o
);

    import rv_pkg::*;

    logic flush_en;

    // a flush only counts on an edge where the pipeline moves.
    assign flush_en = flush_i && advance_i;

    always_ff @(posedge clk) begin
        if (rst || flush_en) begin
            mem_o.valid      <= 1'b0;
            mem_o.rd_index   <= '0;
            mem_o.rd_en      <= 1'b0;
            mem_o.mem_read   <= 1'b0;
            mem_o.mem_write  <= 1'b0;
            mem_o.mem_kind   <= MEM_NONE;
            mem_o.trap       <= 1'b0;
            mem_o.result     <= '0;
            mem_o.store_data <= '0;
        end else if (advance_i) begin
            mem_o.valid      <= ex_i.valid;
            mem_o.rd_index   <= ex_i.rd_index;
            mem_o.rd_en      <= ex_i.rd_en;
            mem_o.mem_read   <= ex_i.mem_read;
            mem_o.mem_write  <= ex_i.mem_write;
            mem_o.mem_kind   <= ex_i.mem_kind;
            mem_o.trap       <= ex_i.trap;
            mem_o.result     <= ex_i.result;
            mem_o.store_data <= ex_i.store_data;
        end
    end

endmodule

/* source/mem_result.sv */
`timescale 1ns/1ps

module mem_result (
    input  logic             clk,
    input  logic             rst,
    input  logic             advance_i,
    ex_mem_if.dst            mem_i,
    output logic             we_o,
    output rv_pkg::reg_idx_t wa_o,
    output rv_pkg::xlen_t    wd_o,
    output logic             retire_o,
    output logic             wb_en_o,
    output rv_pkg::reg_idx_t wb_rd_o,
    output rv_pkg::xlen_t    wb_data_o,
    output logic             trap_o
);

    import rv_pkg::*;

    xlen_t      dmem [DMEM_WORDS];
    mem_addr_t  addr;
    logic [4:0] word_idx;
    logic [5:0] lane_shift;
    xlen_t      cur_word;
    logic [7:0] byte_mask;
    xlen_t      bit_mask;
    xlen_t      store_word;
    logic       store_en;
    xlen_t      lane_data;
    xlen_t      load_data;
    xlen_t      wb_value;

    // bits 7:3 pick the doubleword and bits 2:0 the byte lane.
    assign addr       = mem_i.result[7:0];
    assign word_idx   = addr[7:3];
    assign lane_shift = {addr[2:0], 3'b000};
    assign cur_word   = dmem[word_idx];

    //////////////////////////////
    // store byte lanes.
    //////////////////////////////
    always_comb begin
        case (mem_i.mem_kind)
            MEM_B, MEM_BU: byte_mask = 8'h01 << addr[2:0];
            MEM_H, MEM_HU: byte_mask = 8'h03 << addr[2:0];
            MEM_W, MEM_WU: byte_mask = 8'h0f << addr[2:0];
            MEM_D:         byte_mask = 8'hff;
            default:       byte_mask = 8'h00;
        endcase
        for (int i = 0; i < 8; i++) begin
            bit_mask[8*i +: 8] = {8{byte_mask[i]}};
        end
    end

    assign store_word = (cur_word & ~bit_mask) | ((mem_i.store_data << lane_shift) & bit_mask);
    assign store_en   = advance_i && mem_i.valid && mem_i.mem_write;

    always_ff @(posedge clk) begin
        if (store_en) begin
            dmem[word_idx] <= store_word;
        end
    end

    //////////////////////////////
    // load extension.
    //////////////////////////////
    assign lane_data = cur_word >> lane_shift;

    always_comb begin
        case (mem_i.mem_kind)
            MEM_B:   load_data = {{56{lane_data[7]}}, lane_data[7:0]};
            MEM_H:   load_data = {{48{lane_data[15]}}, lane_data[15:0]};
            MEM_W:   load_data = {{32{lane_data[31]}}, lane_data[31:0]};
            MEM_BU:  load_data = {56'b0, lane_data[7:0]};
            MEM_HU:  load_data = {48'b0, lane_data[15:0]};
            MEM_WU:  load_data = {32'b0, lane_data[31:0]};
            default: load_data = lane_data;
        endcase
    end

    assign wb_value = mem_i.mem_read ? load_data : mem_i.result;

    // x0 is never reported as written.
    assign we_o = advance_i && mem_i.valid && mem_i.rd_en && (mem_i.rd_index != 5'd0);
    assign wa_o = mem_i.rd_index;
    assign wd_o = wb_value;

    always_ff @(posedge clk) begin
        if (rst) begin
            retire_o  <= 1'b0;
            wb_en_o   <= 1'b0;
            wb_rd_o   <= '0;
            wb_data_o <= '0;
            trap_o    <= 1'b0;
        end else if (advance_i) begin
            retire_o  <= mem_i.valid;
            wb_en_o   <= we_o;
            wb_rd_o   <= mem_i.rd_index;
            wb_data_o <= wb_value;
            trap_o    <= mem_i.valid && mem_i.trap;
        end else begin
            // a held edge keeps the record but does not report it again.
            retire_o <= 1'b0;
            wb_en_o  <= 1'b0;
        end
    end

endmodule

/* source/core_slice.sv */
`timescale 1ns/1ps

module core_slice (
    input  logic             clk,
    input  logic             rst,
    input  logic             inst_valid_i,
    input  rv_pkg::inst_t    inst_i,
    input  logic             hold_i,
    input  logic             flush_i,
    output logic             retire_o,
    output logic             wb_en_o,
    output rv_pkg::reg_idx_t wb_rd_o,
    output rv_pkg::xlen_t    wb_data_o,
    output logic             trap_o
);

    import rv_pkg::*;

    logic      advance;
    reg_idx_t  rs1_index;
    reg_idx_t  rs2_index;
    xlen_t     rs1_data;
    xlen_t     rs2_data;
    logic      rf_we;
    reg_idx_t  rf_wa;
    xlen_t     rf_wd;

    logic      id_valid;
    alu_op_e   id_alu_op;
    xlen_t     id_op_a;
    xlen_t     id_op_b;
    xlen_t     id_store_data;
    reg_idx_t  id_rd_index;
    logic      id_rd_en;
    logic      id_mem_read;
    logic      id_mem_write;
    mem_kind_e id_mem_kind;
    logic      id_trap;

    ex_mem_if ex_bus ();
    ex_mem_if mem_bus ();

    // every stage register moves on the same enable.
    assign advance = !hold_i;

    inst_decode decode0 (
        .clk          (clk),
        .rst          (rst),
        .advance_i    (advance),
        .inst_valid_i (inst_valid_i),
        .inst_i       (inst_i),
        .rs1_data_i   (rs1_data),
        .rs2_data_i   (rs2_data),
        .rs1_index_o  (rs1_index),
        .rs2_index_o  (rs2_index),
        .valid_o      (id_valid),
        .alu_op_o     (id_alu_op),
        .op_a_o       (id_op_a),
        .op_b_o       (id_op_b),
        .store_data_o (id_store_data),
        .rd_index_o   (id_rd_index),
        .rd_en_o      (id_rd_en),
        .mem_read_o   (id_mem_read),
        .mem_write_o  (id_mem_write),
        .mem_kind_o   (id_mem_kind),
        .trap_o       (id_trap)
    );

    reg_file regs0 (
        .clk   (clk),
        .rst   (rst),
        .ra_i  (rs1_index),
        .rb_i  (rs2_index),
        .we_i  (rf_we),
        .wa_i  (rf_wa),
        .wd_i  (rf_wd),
        .rda_o (rs1_data),
        .rdb_o (rs2_data)
    );

    alu_execute execute0 (
        .valid_i      (id_valid),
        .alu_op_i     (id_alu_op),
        .op_a_i       (id_op_a),
        .op_b_i       (id_op_b),
        .store_data_i (id_store_data),
        .rd_index_i   (id_rd_index),
        .rd_en_i      (id_rd_en),
        .mem_read_i   (id_mem_read),
        .mem_write_i  (id_mem_write),
        .mem_kind_i   (id_mem_kind),
        .trap_i       (id_trap),
        .ex_o         (ex_bus.src)
    );

    ex2mem ex2mem0 (
        .clk       (clk),
        .rst       (rst),
        .advance_i (advance),
        .flush_i   (flush_i),
        .ex_i      (ex_bus.dst),
        .mem_o     (mem_bus.src)
    );

    mem_result result0 (
        .clk       (clk),
        .rst       (rst),
        .advance_i (advance),
        .mem_i     (mem_bus.dst),
        .we_o      (rf_we),
        .wa_o      (rf_wa),
        .wd_o      (rf_wd),
        .retire_o  (retire_o),
        .wb_en_o   (wb_en_o),
        .wb_rd_o   (wb_rd_o),
        .wb_data_o (wb_data_o),
        .trap_o    (trap_o)
    );

endmodule

/* verif/core_model.svh */
`ifndef CORE_MODEL_SVH
`define CORE_MODEL_SVH

typedef struct packed {
    logic        wb_en;
    logic [4:0]  rd;
    logic [63:0] data;
    logic        trap;
} retire_rec_t;

logic [63:0] rng_state = 64'd74;
xlen_t       m_regs [32];
logic [7:0]  m_mem [256];
retire_rec_t exp_q [$];

function automatic logic [63:0] xorshift64();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 7);
    rng_state = rng_state ^ (rng_state << 17);
    return rng_state;
endfunction

function automatic void model_reset();
    for (int i = 0; i < 32; i++) begin
        m_regs[i] = '0;
    end
    for (int i = 0; i < 256; i++) begin
        m_mem[i] = '0;
    end
endfunction

//////////////////////////////
// instruction encoders.
//////////////////////////////
function automatic inst_t enc_r(logic [6:0] f7, logic [2:0] f3, reg_idx_t rd,
                                reg_idx_t rs1, reg_idx_t rs2);
    return {f7, rs2, rs1, f3, rd, OPC_OP};
endfunction

function automatic inst_t enc_i(opcode_t opc, logic [2:0] f3, reg_idx_t rd,
                                reg_idx_t rs1, logic [11:0] imm);
    return {imm, rs1, f3, rd, opc};
endfunction

function automatic inst_t enc_s(logic [2:0] f3, reg_idx_t rs1, reg_idx_t rs2, logic [11:0] imm);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], OPC_STORE};
endfunction

function automatic inst_t enc_u(reg_idx_t rd, logic [19:0] imm);
    return {imm, rd, OPC_LUI};
endfunction

//////////////////////////////
// architectural behavior.
//////////////////////////////
function automatic xlen_t alu_ref(logic [2:0] f3, logic sub, xlen_t a, xlen_t b);
    xlen_t r;
    case (f3)
        3'd0:    r = sub ? a - b : a + b;
        3'd1:    r = a << b[5:0];
        3'd4:    r = a ^ b;
        3'd5:    r = a >> b[5:0];
        3'd6:    r = a | b;
        default: r = a & b;
    endcase
    return r;
endfunction

// x0 keeps zero and is never reported as written.
function automatic retire_rec_t write_reg(reg_idx_t rd, xlen_t val);
    retire_rec_t rec;
    rec.wb_en = (rd != 5'd0);
    rec.rd    = rd;
    rec.data  = val;
    rec.trap  = 1'b0;
    if (rd != 5'd0) begin
        m_regs[rd] = val;
    end
    return rec;
endfunction

// funct3 bits 1:0 give the size and bit 2 marks an unsigned load.
function automatic xlen_t load_ref(logic [2:0] f3, logic [7:0] addr);
    int    nbytes;
    xlen_t v;
    nbytes = 1 << f3[1:0];
    v = '0;
    for (int i = 0; i < nbytes; i++) begin
        v[8*i +: 8] = m_mem[int'(addr) + i];
    end
    if (!f3[2]) begin
        case (nbytes)
            1:       v = {{56{v[7]}}, v[7:0]};
            2:       v = {{48{v[15]}}, v[15:0]};
            4:       v = {{32{v[31]}}, v[31:0]};
            default: v = v;
        endcase
    end
    return v;
endfunction

function automatic void store_ref(logic [2:0] f3, logic [7:0] addr, xlen_t data);
    for (int i = 0; i < (1 << f3[1:0]); i++) begin
        m_mem[int'(addr) + i] = data[8*i +: 8];
    end
endfunction

`endif

/* verif/tb_core_slice.sv */
`timescale 1ns/1ps

module tb_core_slice;

    import rv_pkg::*;

    `include "core_model.svh"

    localparam int N_ALU  = 40;
    localparam int N_MEM  = 24;
    localparam int N_HOLD = 40;
    // register setup, store fill, size sweep, flush and trap sections, idle slots.
    localparam int TOTAL_SLOTS     = 32 + N_ALU + 32 + 4 * 8 + N_MEM + N_HOLD + 12 + 10 + 20;
    localparam int WATCHDOG_CYCLES = TOTAL_SLOTS * 2 + 200;

    logic     clk;
    logic     rst;
    logic     inst_valid;
    inst_t    inst;
    logic     hold;
    logic     flush;
    logic     retire;
    logic     wb_en;
    reg_idx_t wb_rd;
    xlen_t    wb_data;
    logic     trap;

    logic     hold_mode = 1'b0;
    logic     flush_next = 1'b0;
    logic     started = 1'b0;
    logic     first_seen = 1'b0;
    reg_idx_t last_rd = '0;
    int       adv_count = 0;
    string    cur_test = "reset";

    core_slice dut0 (
        .clk          (clk),
        .rst          (rst),
        .inst_valid_i (inst_valid),
        .inst_i       (inst),
        .hold_i       (hold),
        .flush_i      (flush),
        .retire_o     (retire),
        .wb_en_o      (wb_en),
        .wb_rd_o      (wb_rd),
        .wb_data_o    (wb_data),
        .trap_o       (trap)
    );

    always #50 clk = ~clk;

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("STATUS: FAIL");
        $fatal(1);
    endtask

    function automatic logic records_match(retire_rec_t e, retire_rec_t a);
        return (e.wb_en == a.wb_en) && (e.trap == a.trap) &&
               (!e.wb_en || ((e.rd == a.rd) && (e.data == a.data)));
    endfunction

    //////////////////////////////
    // checking.
    //////////////////////////////
    property quiet_until_start;
        @(negedge clk) (rst || !started) |-> (!retire && !wb_en && !trap);
    endproperty

    assert property (quiet_until_start)
        else report_failure("outputs were active during reset or before the first instruction");

    // a held or empty edge must not report a register write.
    property wb_only_on_retire;
        @(negedge clk) !retire |-> !wb_en;
    endproperty

    assert property (wb_only_on_retire)
        else report_failure("a register write was reported without a retire");

    always @(posedge clk) begin
        if (!rst && started && !hold) begin
            adv_count <= adv_count + 1;
        end
    end

    always @(negedge clk) begin
        retire_rec_t exp_rec;
        retire_rec_t act_rec;
        if (!rst && retire) begin
            assert (exp_q.size() > 0)
                else report_failure("a retire appeared with no instruction outstanding");
            exp_rec = exp_q.pop_front();
            act_rec.wb_en = wb_en;
            act_rec.rd    = wb_rd;
            act_rec.data  = wb_data;
            act_rec.trap  = trap;
            assert (records_match(exp_rec, act_rec))
                else report_failure($sformatf("mismatch in %s: expected %h, actual %h",
                                              cur_test, exp_rec, act_rec));
            if (!first_seen) begin
                first_seen = 1'b1;
                assert (adv_count == 3)
                    else report_failure($sformatf("mismatch in %s: expected %0d, actual %0d",
                                                  cur_test, 3, adv_count));
            end
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout: the instruction stream did not finish in time");
        $display("STATUS: FAIL");
        $fatal(1);
    end

    //////////////////////////////
    // stimulus.
    //////////////////////////////
    // a held slot presents the same instruction again on the next falling edge.
    task automatic drive_slot(input logic valid, input inst_t word);
        logic [63:0] rnd;
        logic        held;
        do begin
            @(negedge clk);
            rnd        = xorshift64();
            held       = hold_mode && (rnd[1:0] == 2'b00);
            inst_valid = valid;
            inst       = word;
            hold       = held;
            flush      = flush_next;
        end while (held);
        flush_next = 1'b0;
    endtask

    task automatic issue(input inst_t word, input retire_rec_t rec);
        drive_slot(1'b1, word);
        started = 1'b1;
        exp_q.push_back(rec);
        last_rd = rec.wb_en ? rec.rd : 5'd0;
    endtask

    // the next slot flushes this one out of execute.
    task automatic issue_killed(input inst_t word);
        drive_slot(1'b1, word);
        flush_next = 1'b1;
        last_rd    = '0;
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            drive_slot(1'b0, enc_i(OPC_OP_IMM, 3'b000, 5'd5, 5'd1, 12'h07f));
        end
        last_rd = '0;
    endtask

    function automatic reg_idx_t rand_reg();
        logic [63:0] rnd;
        rnd = xorshift64();
        return {1'b0, rnd[3:0]};
    endfunction

    // there is no forwarding, so a source must not be the previous slot's destination.
    function automatic reg_idx_t pick_src();
        reg_idx_t r;
        do begin
            r = rand_reg();
        end while (r != 5'd0 && r == last_rd);
        return r;
    endfunction

    task automatic do_rr(input logic [2:0] f3, input logic sub, input reg_idx_t rd,
                         input reg_idx_t rs1, input reg_idx_t rs2);
        xlen_t val;
        val = alu_ref(f3, sub, m_regs[rs1], m_regs[rs2]);
        issue(enc_r(sub ? 7'b0100000 : 7'b0000000, f3, rd, rs1, rs2), write_reg(rd, val));
    endtask

    task automatic do_ri(input logic [2:0] f3, input reg_idx_t rd, input reg_idx_t rs1,
                         input logic [11:0] imm);
        xlen_t val;
        val = alu_ref(f3, 1'b0, m_regs[rs1], {{52{imm[11]}}, imm});
        issue(enc_i(OPC_OP_IMM, f3, rd, rs1, imm), write_reg(rd, val));
    endtask

    task automatic do_lui(input reg_idx_t rd, input logic [19:0] imm);
        issue(enc_u(rd, imm), write_reg(rd, {{32{imm[19]}}, imm, 12'h000}));
    endtask

    task automatic do_load(input logic [2:0] f3, input reg_idx_t rd, input logic [7:0] addr);
        xlen_t val;
        val = load_ref(f3, addr);
        issue(enc_i(OPC_LOAD, f3, rd, 5'd0, {4'b0, addr}), write_reg(rd, val));
    endtask

    task automatic do_store(input logic [2:0] f3, input reg_idx_t rs2, input logic [7:0] addr);
        retire_rec_t rec;
        rec = '0;
        store_ref(f3, addr, m_regs[rs2]);
        issue(enc_s(f3, 5'd0, rs2, {4'b0, addr}), rec);
    endtask

    task automatic do_trap(input logic ebreak);
        retire_rec_t rec;
        rec      = '0;
        rec.trap = 1'b1;
        issue({11'b0, ebreak, 13'b0, OPC_SYSTEM}, rec);
    endtask

    task automatic random_alu();
        logic [63:0] rnd;
        logic [2:0]  f3;
        reg_idx_t    rd;
        reg_idx_t    rs1;
        reg_idx_t    rs2;
        rnd = xorshift64();
        rd  = rand_reg();
        rs1 = pick_src();
        rs2 = pick_src();
        case (rnd[1:0])
            2'd0, 2'd1: begin
                f3 = (rnd[10:8] == 3'd2 || rnd[10:8] == 3'd3) ? 3'd0 : rnd[10:8];
                do_rr(f3, rnd[11] && (f3 == 3'd0), rd, rs1, rs2);
            end
            2'd2: begin
                case (rnd[9:8])
                    2'd0:    f3 = 3'd0;
                    2'd1:    f3 = 3'd4;
                    2'd2:    f3 = 3'd6;
                    default: f3 = 3'd7;
                endcase
                do_ri(f3, rd, rs1, rnd[31:20]);
            end
            default: do_lui(rd, rnd[51:32]);
        endcase
    endtask

    task automatic random_mem();
        logic [63:0] rnd;
        logic [2:0]  f3;
        logic [2:0]  off;
        rnd = xorshift64();
        if (rnd[0]) begin
            f3 = {1'b0, rnd[2:1]};
        end else begin
            f3 = (rnd[3:1] == 3'd7) ? 3'd3 : rnd[3:1];
        end
        off = rnd[10:8] & ~3'((1 << f3[1:0]) - 1);
        if (rnd[0]) begin
            do_store(f3, pick_src(), {rnd[15:11], off});
        end else begin
            do_load(f3, rand_reg(), {rnd[15:11], off});
        end
    endtask

    initial begin
        logic [63:0] rnd;
        logic [2:0]  off;
        clk        = 1'b0;
        rst        = 1'b1;
        inst_valid = 1'b0;
        inst       = '0;
        hold       = 1'b0;
        flush      = 1'b0;
        model_reset();
        repeat (16) @(negedge clk);
        rst = 1'b0;

        cur_test = "alu";
        for (int i = 1; i < 16; i++) begin
            rnd = xorshift64();
            do_lui(5'(i), rnd[19:0]);
        end
        for (int i = 1; i < 16; i++) begin
            rnd = xorshift64();
            do_ri(3'd0, 5'(i), 5'(i), rnd[11:0]);
        end
        do_ri(3'd0, 5'd0, 5'd3, 12'h123);
        do_rr(3'd6, 1'b0, 5'd4, 5'd0, 5'd5);
        repeat (N_ALU) random_alu();

        cur_test = "memory";
        for (int w = 0; w < 32; w++) begin
            do_store(3'd3, pick_src(), 8'(w * 8));
        end
        for (int s = 0; s < 4; s++) begin
            off = (s == 3) ? 3'd0 : 3'd4;
            do_store(3'(s), pick_src(), {5'(8 + s), off});
            for (int k = 0; k < 7; k++) begin
                do_load(3'(k), 5'(k + 1), {5'(8 + s), off & ~3'((1 << k[1:0]) - 1)});
            end
        end
        repeat (N_MEM) random_mem();
        idle(4);
        assert (exp_q.size() == 0) else report_failure("retires are missing after the memory test");

        cur_test = "hold";
        hold_mode = 1'b1;
        repeat (N_HOLD) begin
            rnd = xorshift64();
            if (rnd[0]) begin
                random_alu();
            end else begin
                random_mem();
            end
        end
        hold_mode = 1'b0;
        idle(4);
        assert (exp_q.size() == 0) else report_failure("retires are missing after the hold test");

        cur_test = "flush";
        do_store(3'd3, 5'd3, 8'h40);
        issue_killed(enc_s(3'd3, 5'd0, 5'd0, 12'h040));
        do_ri(3'd0, 5'd6, 5'd0, 12'h001);
        idle(1);
        do_load(3'd3, 5'd7, 8'h40);
        issue_killed(enc_i(OPC_OP_IMM, 3'd0, 5'd8, 5'd0, 12'h07b));
        do_ri(3'd0, 5'd9, 5'd0, 12'h002);
        idle(1);
        do_rr(3'd0, 1'b0, 5'd10, 5'd8, 5'd0);

        cur_test = "trap";
        do_trap(1'b0);
        idle(1);
        do_trap(1'b1);
        do_trap(1'b0);
        idle(3);
        random_alu();
        idle(5);

        if (exp_q.size() == 0) begin
            $display("STATUS: PASS");
            $finish;
        end else begin
            report_failure("instructions never retired by the end");
        end
    end

endmodule

/* files.f */
+incdir+verif
source/rv_pkg.sv
source/ex_mem_if.sv
source/reg_file.sv
source/inst_decode.sv
source/alu_execute.sv
source/ex2mem.sv
source/mem_result.sv
source/core_slice.sv
verif/tb_core_slice.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the core_slice testbench with Verilator.
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --assert -Wno-fatal --top-module tb_core_slice -f files.f \
    -o sim_core_slice > build.log 2>&1 \
    && ./obj_dir/sim_core_slice > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "STATUS: PASS" sim.log && ! grep -q "STATUS: FAIL" sim.log \
    && echo "simulation passed" && exit 0 \
    || { echo "simulation failed, see build.log and sim.log"; exit 1; }
